// ==== src/id_ser_pkg.sv ====
package id_ser_pkg;

  // Port ID widths and slot geometry
  localparam int unsigned SLV_ID_W        = 6;
  localparam int unsigned MST_ID_W        = 2;
  localparam int unsigned NUM_SLOTS       = 4;
  localparam int unsigned MAX_TXNS_PER_ID = 4;

  // Payload widths
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned RESP_W = 2;

  // R return FIFO sizing
  localparam int unsigned R_FIFO_DEPTH = 2;
  localparam int unsigned R_PTR_W      = (R_FIFO_DEPTH > 1) ? $clog2(R_FIFO_DEPTH) : 1;
  localparam int unsigned R_CNT_W      = $clog2(R_FIFO_DEPTH + 1);

  // Outstanding-read counter must reach MAX_TXNS_PER_ID
  localparam int unsigned SLOT_CNT_W = $clog2(MAX_TXNS_PER_ID + 1);

  typedef logic [SLV_ID_W-1:0]   slv_id_t;
  // Master ID doubles as the slot index
  typedef logic [MST_ID_W-1:0]   mst_id_t;
  typedef logic [ADDR_W-1:0]     addr_t;
  typedef logic [DATA_W-1:0]     data_t;
  typedef logic [RESP_W-1:0]     resp_t;
  typedef logic [SLOT_CNT_W-1:0] slot_cnt_t;

  typedef struct packed {
    slv_id_t id;
    addr_t   addr;
  } ar_slv_t;

  typedef struct packed {
    mst_id_t id;
    addr_t   addr;
  } ar_mst_t;

  typedef struct packed {
    mst_id_t id;
    data_t   data;
    resp_t   resp;
  } r_mst_t;

  typedef struct packed {
    slv_id_t id;
    data_t   data;
    resp_t   resp;
  } r_slv_t;

endpackage

// ==== src/slot_ctrl.sv ====
`timescale 1ns/1ps

module slot_ctrl (
  input  logic                clk_i,
  input  logic                rst_i,
  // Slave AR side
  input  id_ser_pkg::ar_slv_t slv_ar_i,
  input  logic                slv_ar_valid_i,
  output logic                slv_ar_ready_o,
  // AR skid side
  input  logic                skid_ready_i,
  output logic                ar_push_o,
  output id_ser_pkg::ar_mst_t ar_o,
  // R side
  input  id_ser_pkg::r_mst_t  mst_r_i,
  input  logic                r_done_i,
  output id_ser_pkg::r_slv_t  r_slv_o
);

  // Per-slot state
  id_ser_pkg::slot_cnt_t cnt_q   [id_ser_pkg::NUM_SLOTS];
  id_ser_pkg::slot_cnt_t cnt_d   [id_ser_pkg::NUM_SLOTS];
  id_ser_pkg::slv_id_t   owner_q [id_ser_pkg::NUM_SLOTS];

  id_ser_pkg::mst_id_t   ar_slot;
  id_ser_pkg::mst_id_t   r_slot;
  logic                  slot_idle;
  logic                  slot_same_id;
  logic                  slot_has_room;
  logic                  admit;

  // Slot is the slave ID modulo NUM_SLOTS, i.e. its low bits
  assign ar_slot = slv_ar_i.id[id_ser_pkg::MST_ID_W-1:0];
  assign r_slot  = mst_r_i.id;

  assign slot_idle     = (cnt_q[ar_slot] == '0);
  assign slot_same_id  = (owner_q[ar_slot] == slv_ar_i.id);
  assign slot_has_room =
    (cnt_q[ar_slot] < id_ser_pkg::slot_cnt_t'(id_ser_pkg::MAX_TXNS_PER_ID));

  // A busy slot only takes more reads of the ID it already serves
  assign admit = slot_idle | (slot_same_id & slot_has_room);

  assign slv_ar_ready_o = admit & skid_ready_i;
  assign ar_push_o      = slv_ar_valid_i & slv_ar_ready_o;

  // Remapped request toward the skid
  always_comb begin
    ar_o      = '0;
    ar_o.id   = ar_slot;
    ar_o.addr = slv_ar_i.addr;
  end

  // Restore the slave ID from the owner of the returning slot
  always_comb begin
    r_slv_o      = '0;
    r_slv_o.id   = owner_q[r_slot];
    r_slv_o.data = mst_r_i.data;
    r_slv_o.resp = mst_r_i.resp;
  end

  // Next count per slot, push and completion may hit the same slot
  always_comb begin
    for (int i = 0; i < id_ser_pkg::NUM_SLOTS; i++) begin
      cnt_d[i] = cnt_q[i];
      if (ar_push_o && (ar_slot == id_ser_pkg::mst_id_t'(i))) begin
        cnt_d[i] = cnt_d[i] + id_ser_pkg::slot_cnt_t'(1);
      end
      if (r_done_i && (r_slot == id_ser_pkg::mst_id_t'(i))) begin
        cnt_d[i] = cnt_d[i] - id_ser_pkg::slot_cnt_t'(1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < id_ser_pkg::NUM_SLOTS; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < id_ser_pkg::NUM_SLOTS; i++) begin
        cnt_q[i] <= cnt_d[i];
      end
    end
  end

  // Owner only matters while the count is nonzero
  always_ff @(posedge clk_i) begin
    if (ar_push_o) begin
      owner_q[ar_slot] <= slv_ar_i.id;
    end
  end

endmodule

// ==== src/ar_skid.sv ====
`timescale 1ns/1ps

module ar_skid (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                push_i,
  input  id_ser_pkg::ar_mst_t ar_i,
  output logic                ready_o,
  output id_ser_pkg::ar_mst_t ar_o,
  output logic                valid_o,
  input  logic                ready_i
);

  // Output stage drives the master port, spare catches one more
  id_ser_pkg::ar_mst_t out_q;
  id_ser_pkg::ar_mst_t spare_q;
  logic                out_valid_q;
  logic                spare_valid_q;
  logic                pop;

  assign pop     = out_valid_q & ready_i;
  assign ready_o = ~spare_valid_q;
  assign ar_o    = out_q;
  assign valid_o = out_valid_q;

  // Valid flags
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      out_valid_q   <= 1'b0;
      spare_valid_q <= 1'b0;
    end else if (spare_valid_q) begin
      // Full, no push possible; spare moves up on pop
      if (pop) begin
        spare_valid_q <= 1'b0;
      end
    end else if (push_i) begin
      out_valid_q <= 1'b1;
      if (out_valid_q && !pop) begin
        spare_valid_q <= 1'b1;
      end
    end else if (pop) begin
      out_valid_q <= 1'b0;
    end
  end

  // Payload registers
  always_ff @(posedge clk_i) begin
    if (spare_valid_q) begin
      if (pop) begin
        out_q <= spare_q;
      end
    end else if (push_i) begin
      if (!out_valid_q || pop) begin
        out_q <= ar_i;
      end else begin
        spare_q <= ar_i;
      end
    end
  end

endmodule

// ==== src/r_fifo.sv ====
`timescale 1ns/1ps

module r_fifo (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               push_i,
  input  id_ser_pkg::r_slv_t r_i,
  output logic               not_full_o,
  output id_ser_pkg::r_slv_t r_o,
  output logic               valid_o,
  input  logic               ready_i
);

  id_ser_pkg::r_slv_t              mem_q [id_ser_pkg::R_FIFO_DEPTH];
  logic [id_ser_pkg::R_PTR_W-1:0]  wr_ptr_q;
  logic [id_ser_pkg::R_PTR_W-1:0]  rd_ptr_q;
  logic [id_ser_pkg::R_CNT_W-1:0]  cnt_q;
  logic                            do_push;
  logic                            do_pop;

  assign not_full_o = (cnt_q != id_ser_pkg::R_CNT_W'(id_ser_pkg::R_FIFO_DEPTH));
  assign valid_o    = (cnt_q != '0);
  assign r_o        = mem_q[rd_ptr_q];

  assign do_push = push_i & not_full_o;
  assign do_pop  = valid_o & ready_i;

  // Pointers wrap at the last entry
  function automatic logic [id_ser_pkg::R_PTR_W-1:0] next_ptr(
    input logic [id_ser_pkg::R_PTR_W-1:0] ptr
  );
    logic [id_ser_pkg::R_PTR_W-1:0] last;
    last = id_ser_pkg::R_PTR_W'(id_ser_pkg::R_FIFO_DEPTH - 1);
    if (ptr == last) begin
      return '0;
    end
    return ptr + id_ser_pkg::R_PTR_W'(1);
  endfunction

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      // Fill count changes only when exactly one side moves
      if (do_push && !do_pop) begin
        cnt_q <= cnt_q + id_ser_pkg::R_CNT_W'(1);
      end else if (do_pop && !do_push) begin
        cnt_q <= cnt_q - id_ser_pkg::R_CNT_W'(1);
      end
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= r_i;
    end
  end

endmodule

// ==== src/id_ser_top.sv ====
`timescale 1ns/1ps

module id_ser_top (
  input  logic                clk_i,
  input  logic                rst_i,
  // Slave port, wide IDs
  input  id_ser_pkg::ar_slv_t slv_ar_i,
  input  logic                slv_ar_valid_i,
  output logic                slv_ar_ready_o,
  output id_ser_pkg::r_slv_t  slv_r_o,
  output logic                slv_r_valid_o,
  input  logic                slv_r_ready_i,
  // Master port, narrow IDs
  output id_ser_pkg::ar_mst_t mst_ar_o,
  output logic                mst_ar_valid_o,
  input  logic                mst_ar_ready_i,
  input  id_ser_pkg::r_mst_t  mst_r_i,
  input  logic                mst_r_valid_i,
  output logic                mst_r_ready_o
);

  // AR path between controller and skid
  logic                skid_ready;
  logic                ar_push;
  id_ser_pkg::ar_mst_t ar_remap;

  // R path between controller and return FIFO
  logic                r_not_full;
  logic                r_done;
  id_ser_pkg::r_slv_t  r_restored;

  // Master R beat is taken whenever the return FIFO has room
  assign mst_r_ready_o = r_not_full;
  assign r_done        = mst_r_valid_i & r_not_full;

  slot_ctrl i_slot_ctrl (
    .clk_i          ( clk_i          ),
    .rst_i          ( rst_i          ),
    .slv_ar_i       ( slv_ar_i       ),
    .slv_ar_valid_i ( slv_ar_valid_i ),
    .slv_ar_ready_o ( slv_ar_ready_o ),
    .skid_ready_i   ( skid_ready     ),
    .ar_push_o      ( ar_push        ),
    .ar_o           ( ar_remap       ),
    .mst_r_i        ( mst_r_i        ),
    .r_done_i       ( r_done         ),
    .r_slv_o        ( r_restored     )
  );

  ar_skid i_ar_skid (
    .clk_i   ( clk_i          ),
    .rst_i   ( rst_i          ),
    .push_i  ( ar_push        ),
    .ar_i    ( ar_remap       ),
    .ready_o ( skid_ready     ),
    .ar_o    ( mst_ar_o       ),
    .valid_o ( mst_ar_valid_o ),
    .ready_i ( mst_ar_ready_i )
  );

  r_fifo i_r_fifo (
    .clk_i      ( clk_i         ),
    .rst_i      ( rst_i         ),
    .push_i     ( r_done        ),
    .r_i        ( r_restored    ),
    .not_full_o ( r_not_full    ),
    .r_o        ( slv_r_o       ),
    .valid_o    ( slv_r_valid_o ),
    .ready_i    ( slv_r_ready_i )
  );

endmodule

// ==== testbench/tb_mem_slave.sv ====
`timescale 1ns/1ps

// Memory-like AXI read slave with one request queue per master ID
module tb_mem_slave #(
  parameter logic [31:0] SEED = 32'h6a3d_0457
) (
  input  logic                clk_i,
  input  logic                rst_i,
  input  id_ser_pkg::ar_mst_t ar_i,
  input  logic                ar_valid_i,
  output logic                ar_ready_o,
  output id_ser_pkg::r_mst_t  r_o,
  output logic                r_valid_o,
  input  logic                r_ready_i
);

  localparam id_ser_pkg::data_t KEY = 32'h5a5a_0f0f;

  id_ser_pkg::addr_t   addr_q [id_ser_pkg::NUM_SLOTS][$];
  id_ser_pkg::ar_mst_t ar_seen;
  id_ser_pkg::mst_id_t start;
  id_ser_pkg::mst_id_t idx;
  id_ser_pkg::mst_id_t pick;
  integer              seed;
  logic [31:0]         rnd;
  logic                ar_fire;
  logic                r_fire;
  logic                in_reset;
  logic                found;

  initial begin
    seed       = SEED;
    ar_ready_o = 1'b0;
    r_valid_o  = 1'b0;
    r_o        = '0;
    forever begin
      // Handshakes are settled by the falling edge
      @(negedge clk_i);
      ar_fire  = ar_valid_i & ar_ready_o;
      r_fire   = r_valid_o & r_ready_i;
      ar_seen  = ar_i;
      in_reset = rst_i;
      @(posedge clk_i);
      #10;
      if (in_reset) begin
        ar_ready_o = 1'b0;
        r_valid_o  = 1'b0;
      end else begin
        if (ar_fire) begin
          addr_q[ar_seen.id].push_back(ar_seen.addr);
        end
        if (r_fire) begin
          r_valid_o = 1'b0;
        end
        rnd        = $random(seed);
        ar_ready_o = rnd[0];
        // Serve a random non-empty ID so returns reorder across IDs
        if (!r_valid_o && rnd[1]) begin
          start = rnd[3:2];
          found = 1'b0;
          pick  = '0;
          for (int k = 0; k < id_ser_pkg::NUM_SLOTS; k++) begin
            idx = start + id_ser_pkg::mst_id_t'(k);
            if (!found && addr_q[idx].size() > 0) begin
              found = 1'b1;
              pick  = idx;
            end
          end
          if (found) begin
            r_o.id    = pick;
            r_o.data  = addr_q[pick].pop_front() ^ KEY;
            r_o.resp  = '0;  // OKAY
            r_valid_o = 1'b1;
          end
        end
      end
    end
  end

endmodule

// ==== testbench/tb_id_ser.sv ====
`timescale 1ns/1ps

module tb_id_ser;

  localparam int unsigned NUM_REQS       = 400;
  localparam int unsigned TIMEOUT_CYCLES = NUM_REQS * 40;
  localparam int unsigned NUM_IDS        = 1 << id_ser_pkg::SLV_ID_W;
  localparam id_ser_pkg::data_t KEY      = 32'h5a5a_0f0f;

  logic                clk_i;
  logic                rst_i;
  id_ser_pkg::ar_slv_t slv_ar_i;
  logic                slv_ar_valid_i;
  logic                slv_ar_ready_o;
  id_ser_pkg::r_slv_t  slv_r_o;
  logic                slv_r_valid_o;
  logic                slv_r_ready_i;
  id_ser_pkg::ar_mst_t mst_ar_o;
  logic                mst_ar_valid_o;
  logic                mst_ar_ready_i;
  id_ser_pkg::r_mst_t  mst_r_i;
  logic                mst_r_valid_i;
  logic                mst_r_ready_o;

  // Reference model, per slave ID data and per slot owner and count
  id_ser_pkg::data_t     exp_data   [NUM_IDS][$];
  id_ser_pkg::ar_mst_t   exp_ar     [$];
  id_ser_pkg::slv_id_t   slot_owner [id_ser_pkg::NUM_SLOTS];
  id_ser_pkg::slot_cnt_t slot_cnt   [id_ser_pkg::NUM_SLOTS];
  int unsigned           done_cnt;
  int unsigned           cycles;
  integer                seed;

  id_ser_top DUT (
    .clk_i          ( clk_i          ),
    .rst_i          ( rst_i          ),
    .slv_ar_i       ( slv_ar_i       ),
    .slv_ar_valid_i ( slv_ar_valid_i ),
    .slv_ar_ready_o ( slv_ar_ready_o ),
    .slv_r_o        ( slv_r_o        ),
    .slv_r_valid_o  ( slv_r_valid_o  ),
    .slv_r_ready_i  ( slv_r_ready_i  ),
    .mst_ar_o       ( mst_ar_o       ),
    .mst_ar_valid_o ( mst_ar_valid_o ),
    .mst_ar_ready_i ( mst_ar_ready_i ),
    .mst_r_i        ( mst_r_i        ),
    .mst_r_valid_i  ( mst_r_valid_i  ),
    .mst_r_ready_o  ( mst_r_ready_o  )
  );

  tb_mem_slave #(
    .SEED ( 32'h6a3d_0457 )
  ) i_mem (
    .clk_i      ( clk_i          ),
    .rst_i      ( rst_i          ),
    .ar_i       ( mst_ar_o       ),
    .ar_valid_i ( mst_ar_valid_o ),
    .ar_ready_o ( mst_ar_ready_i ),
    .r_o        ( mst_r_i        ),
    .r_valid_o  ( mst_r_valid_i  ),
    .r_ready_i  ( mst_r_ready_o  )
  );

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1, "run stopped on first error");
  endtask

  task automatic check_ar(input id_ser_pkg::ar_mst_t got, input id_ser_pkg::ar_mst_t exp);
    if (got !== exp) begin
      fail_run($sformatf("MISMATCH at %0t: master AR id %0d addr %h, expected id %0d addr %h",
                         $time, got.id, got.addr, exp.id, exp.addr));
    end
  endtask

  task automatic check_r(input id_ser_pkg::r_slv_t got, input id_ser_pkg::r_slv_t exp);
    if (got !== exp) begin
      fail_run($sformatf("MISMATCH at %0t: slave R id %0d data %h resp %0d, expected %0d %h %0d",
                         $time, got.id, got.data, got.resp, exp.id, exp.data, exp.resp));
    end
  endtask

  task automatic verify_low(input logic got, input string what);
    if (got !== 1'b0) begin
      fail_run($sformatf("MISMATCH at %0t: %s is %b after reset, expected 0", $time, what, got));
    end
  endtask

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  initial begin
    cycles = 0;
    forever begin
      @(posedge clk_i);
      cycles++;
      if (cycles >= TIMEOUT_CYCLES) begin
        fail_run($sformatf("Timeout: reads not all completed after %0d cycles", cycles));
      end
    end
  end

  // Observe handshakes mid-cycle where every signal is stable
  always @(negedge clk_i) begin : monitor
    id_ser_pkg::mst_id_t slot;
    id_ser_pkg::ar_mst_t exp_req;
    id_ser_pkg::r_slv_t  exp_beat;
    if (rst_i) begin
      done_cnt = 0;
      for (int i = 0; i < id_ser_pkg::NUM_SLOTS; i++) begin
        slot_cnt[i]   = '0;
        slot_owner[i] = '0;
      end
    end else begin
      if (slv_ar_valid_i && slv_ar_ready_o) begin
        slot = id_ser_pkg::mst_id_t'(32'(slv_ar_i.id) % id_ser_pkg::NUM_SLOTS);
        if (slot_cnt[slot] != '0 && slot_owner[slot] != slv_ar_i.id) begin
          fail_run($sformatf("Slot %0d took ID %0d while busy with ID %0d",
                             slot, slv_ar_i.id, slot_owner[slot]));
        end else if (slot_cnt[slot] >= id_ser_pkg::slot_cnt_t'(id_ser_pkg::MAX_TXNS_PER_ID)) begin
          fail_run($sformatf("Slot %0d took a read beyond its outstanding limit", slot));
        end else begin
          slot_owner[slot] = slv_ar_i.id;
          slot_cnt[slot]   = slot_cnt[slot] + id_ser_pkg::slot_cnt_t'(1);
          exp_req.id       = slot;
          exp_req.addr     = slv_ar_i.addr;
          exp_ar.push_back(exp_req);
          exp_data[slv_ar_i.id].push_back(slv_ar_i.addr ^ KEY);
        end
      end
      if (mst_ar_valid_o && mst_ar_ready_i) begin
        if (exp_ar.size() == 0) begin
          fail_run("Master AR issued with no accepted request pending");
        end else begin
          check_ar(mst_ar_o, exp_ar.pop_front());
        end
      end
      if (mst_r_valid_i && mst_r_ready_o) begin
        if (slot_cnt[mst_r_i.id] == '0) begin
          fail_run("Master R returned for a slot with nothing outstanding");
        end else begin
          slot_cnt[mst_r_i.id] = slot_cnt[mst_r_i.id] - id_ser_pkg::slot_cnt_t'(1);
        end
      end
      if (slv_r_valid_o && slv_r_ready_i) begin
        if (exp_data[slv_r_o.id].size() == 0) begin
          fail_run($sformatf("Slave R beat for ID %0d with no read outstanding", slv_r_o.id));
        end else begin
          exp_beat.id   = slv_r_o.id;
          exp_beat.data = exp_data[slv_r_o.id].pop_front();
          exp_beat.resp = '0;
          check_r(slv_r_o, exp_beat);
          done_cnt++;
        end
      end
    end
  end

  initial begin : stimulus
    logic [31:0] rnd;
    logic        ar_fire;
    int unsigned sent;
    int unsigned stall;
    int          pending;
    seed           = 32'h6a3d_0457;
    rst_i          = 1'b1;
    slv_ar_i       = '0;
    slv_ar_valid_i = 1'b0;
    slv_r_ready_i  = 1'b0;
    repeat (10) @(posedge clk_i);
    #10;
    rst_i = 1'b0;
    @(negedge clk_i);
    verify_low(mst_ar_valid_o, "mst_ar_valid_o");
    verify_low(slv_r_valid_o, "slv_r_valid_o");

    sent  = 0;
    stall = 0;
    while (done_cnt < NUM_REQS) begin
      @(negedge clk_i);
      ar_fire = slv_ar_valid_i & slv_ar_ready_o;
      @(posedge clk_i);
      #10;
      if (ar_fire) begin
        sent++;
        slv_ar_valid_i = 1'b0;
      end
      rnd = $random(seed);
      // Eight IDs, two per slot, upper bit set on half of them
      if (!slv_ar_valid_i && sent < NUM_REQS && rnd[1:0] != 2'b00) begin
        slv_ar_i.id    = {rnd[4], 3'b000, rnd[3:2]};
        slv_ar_i.addr  = $random(seed);
        slv_ar_valid_i = 1'b1;
      end
      // Slave R back-pressure with occasional long stalls
      if (stall != 0) begin
        slv_r_ready_i = 1'b0;
        stall--;
      end else if (rnd[9:5] == 5'd0) begin
        stall         = 16 + 32'(rnd[15:10]);
        slv_r_ready_i = 1'b0;
      end else begin
        slv_r_ready_i = (rnd[31:30] != 2'b00);
      end
    end

    pending = exp_ar.size();
    for (int i = 0; i < NUM_IDS; i++) begin
      pending += exp_data[i].size();
    end
    for (int i = 0; i < id_ser_pkg::NUM_SLOTS; i++) begin
      pending += 32'(slot_cnt[i]);
    end
    if (pending != 0) begin
      fail_run($sformatf("Model still holds %0d outstanding entries at the end", pending));
    end else begin
      $display("sim passed");
      $finish;
    end
  end

endmodule

// ==== sim.f ====
src/id_ser_pkg.sv
src/slot_ctrl.sv
src/ar_skid.sv
src/r_fifo.sv
src/id_ser_top.sv
testbench/tb_mem_slave.sv
testbench/tb_id_ser.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
  -f sim.f \
  --top-module tb_id_ser \
  -Mdir obj_dir \
  -o tb_id_ser_sim

./obj_dir/tb_id_ser_sim
